/* sim.f */
+incdir+hdl
hdl/cplx_pkg.sv
hdl/pattern_rom.sv
hdl/victim_decode.sv
hdl/lane_mapper.sv
hdl/cplx_pattern_gen.sv
bench/cplx_checker.sv
bench/cplx_properties.sv
bench/tb_cplx_pattern_gen.sv

/* run.sh */
#!/bin/sh
# verilator build and run of the pattern generator testbench
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_cplx_pattern_gen \
        -f sim.f -o tb_sim; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

/* bench/tb_cplx_pattern_gen.sv */
//**********************************************************
// complex pattern generator testbench
// table driven stimulus, checker hookup and run timeout
//**********************************************************
`include "cplx_defines.svh"

module tb_cplx_pattern_gen;

    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 3;   // two edge latency plus margin

    // one stimulus row
    typedef struct packed {
        logic                        reset;  // synchronous reset for the whole row
        logic                        restart;
        logic                        inc;
        logic [2:0]                  victim_sel;
        logic [`CPLX_BYTE_CNT_W-1:0] byte_cnt;
        logic [15:0]                 reps;   // cycles the row is held
        logic                        rnd;    // fresh random selects each cycle
    } stim_row_t;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               restart;
    logic                               inc;
    logic [2:0]                         victim_sel;
    logic [`CPLX_BYTE_CNT_W-1:0]        byte_cnt;
    logic [`CPLX_DQ_WIDTH*`CPLX_BL-1:0] cplx_data;
    logic [8*`CPLX_BL-1:0]              cplx_byte;
    logic [`CPLX_ADDR_W-1:0]            rd_addr;
    int                                 err_cnt;
    int                                 chk_cnt;
    logic [4:0]                         ref_seen;   // reference addresses checked
    stim_row_t                          stim_q[$];
    integer                             seed = 19;
    int                                 cycle_cnt = 0;
    int                                 cycle_limit = 100000;   // replaced at time 0

    always #10 clk = ~clk;

    cplx_pattern_gen #(.ISI_PAT_EN(1'b0)) cplx_pattern_gen_inst (
        .clk_i(clk), .rst_i(rst), .restart_i(restart), .inc_i(inc),
        .victim_sel_i(victim_sel), .byte_cnt_i(byte_cnt),
        .cplx_data_o(cplx_data), .cplx_byte_o(cplx_byte), .rd_addr_o(rd_addr)
    );

    cplx_checker #(.ISI_EN(1'b0)) checker_inst (
        .clk_i(clk), .rst_i(rst), .restart_i(restart), .inc_i(inc),
        .victim_sel_i(victim_sel), .byte_cnt_i(byte_cnt),
        .cplx_data_i(cplx_data), .cplx_byte_i(cplx_byte), .rd_addr_i(rd_addr),
        .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt), .ref_seen_o(ref_seen)
    );

    task automatic add_row(input logic rs, input logic in, input logic [2:0] vs,
                           input logic [4:0] bc, input int reps, input logic rnd);
        stim_q.push_back({1'b0, rs, in, vs, bc, 16'(reps), rnd});
    endtask

    // reset row, selects held at zero
    task automatic add_reset_row(input int reps);
        stim_q.push_back({1'b1, 1'b0, 1'b0, 3'd0, 5'd0, 16'(reps), 1'b0});
    endtask

    // hold one row with inputs 2 units after the edge
    task automatic apply_row(input stim_row_t row);
        for (int i = 0; i < int'(row.reps); i++) begin
            @(posedge clk);
            #2;
            rst     = row.reset;
            restart = row.restart;
            inc     = row.inc;
            if (row.rnd) begin
                victim_sel = 3'($random(seed));
                byte_cnt   = 5'({$random(seed)} % 4);   // bytes 0..3 only
            end else begin
                victim_sel = row.victim_sel;
                byte_cnt   = row.byte_cnt;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout, run went past %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        rst        = 1'b1;
        restart    = 1'b0;
        inc        = 1'b0;
        victim_sel = '0;
        byte_cnt   = '0;
        add_row(0, 0, 0, 0, 3, 0);      // idle at address 0
        add_row(0, 1, 3, 1, 21, 0);     // walk to 21
        add_row(0, 0, 3, 1, 4, 0);
        add_row(0, 1, 5, 2, 21, 0);     // walk to 42
        add_row(0, 0, 5, 2, 3, 0);
        add_reset_row(RESET_CYCLES);    // victim lane cleared while 42 is still out
        add_row(1, 1, 6, 0, 1, 0);      // restart beats inc
        add_row(0, 0, 6, 0, 4, 0);
        add_row(0, 1, 0, 0, 100, 1);    // to 100 with random lanes
        add_row(0, 0, 2, 3, 3, 0);
        add_row(0, 1, 7, 3, 26, 0);     // to 126 the last vccaux entry
        add_row(0, 0, 1, 0, 3, 1);
        add_row(0, 1, 0, 0, 260, 1);    // through isi and spare and wrap to 130
        add_row(1, 0, 4, 2, 1, 0);
        add_row(0, 0, 4, 2, 4, 1);
        add_row(0, 1, 0, 0, 40, 1);
        total = 0;
        foreach (stim_q[r]) total += int'(stim_q[r].reps);
        cycle_limit = total + RESET_CYCLES + DRAIN_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (stim_q[r]) apply_row(stim_q[r]);
        @(posedge clk);
        #2;
        restart = 1'b0;
        inc     = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        #1;                               // checker done with this cycle
        if (ref_seen != 5'b11111) begin
            $display("not every reference address reached the outputs");
        end
        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0 && ref_seen == 5'b11111) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/cplx_properties.sv */
//**********************************************************
// pattern rom properties
// region decode range and isi masking of the word register
//**********************************************************
module cplx_properties (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    isi_en_i,   // rom isi enable
    input logic [2:0]              region_i,
    input cplx_pkg::pattern_word_t word_i
);

    // five regions only
    a_region_legal : assert property (@(posedge clk_i) disable iff (rst_i)
        region_i <= cplx_pkg::REGION_SPARE)
        else $error("pattern rom region value out of range");

    // word register loads one edge after the region decode
    a_isi_masked : assert property (@(posedge clk_i) disable iff (rst_i)
        (!isi_en_i && (region_i == cplx_pkg::REGION_ISI ||
                       region_i == cplx_pkg::REGION_SPARE)) |=> (word_i == '0))
        else $error("pattern rom word not zero in a masked region");

endmodule

bind pattern_rom cplx_properties cplx_properties_inst (
    .clk_i(clk_i), .rst_i(rst_i), .isi_en_i(ISI_PAT_EN), .region_i(region), .word_i(word_o)
);

/* bench/cplx_checker.sv */
//**********************************************************
// pattern generator checker
// models counter and output stage and compares every cycle
//**********************************************************
`include "cplx_defines.svh"

module cplx_checker #(
    parameter bit ISI_EN = 1'b1                 // isi and spare unmasked in the dut
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               restart_i,
    input  logic                               inc_i,
    input  logic [2:0]                         victim_sel_i,
    input  logic [`CPLX_BYTE_CNT_W-1:0]        byte_cnt_i,
    input  logic [`CPLX_DQ_WIDTH*`CPLX_BL-1:0] cplx_data_i,
    input  logic [8*`CPLX_BL-1:0]              cplx_byte_i,
    input  logic [`CPLX_ADDR_W-1:0]            rd_addr_i,
    output int                                 err_cnt_o,
    output int                                 chk_cnt_o,
    output logic [4:0]                         ref_seen_o
);

    localparam int N_REF = 5;
    localparam logic [7:0]  REF_ADDR [N_REF] = '{8'd0, 8'd21, 8'd42, 8'd100, 8'd126};
    localparam logic [15:0] REF_WORD [N_REF] = '{16'hAAAA, 16'hAA55, 16'hB457, 16'hAA31,
                                                 16'h0221};

    int                          err_cnt = 0;
    int                          chk_cnt = 0;
    logic [4:0]                  ref_seen = '0;
    logic [7:0]                  cnt_m = '0;          // modeled rom counter
    logic [7:0]                  addr_m = '0;         // modeled rd_addr_o
    logic                        cnt_known = 1'b0;
    logic                        addr_known = 1'b0;
    logic                        vic_on = 1'b0;       // victim decode out of reset
    logic [2:0]                  vsel_m = '0;
    logic [`CPLX_BYTE_CNT_W-1:0] byte_m = '0;

    assign err_cnt_o  = err_cnt;
    assign chk_cnt_o  = chk_cnt;
    assign ref_seen_o = ref_seen;

    // beat k of a lane is pattern bit 7-k
    function automatic logic [7:0] reverse_bits(input logic [7:0] p);
        logic [7:0] r;
        for (int k = 0; k < 8; k++) r[k] = p[7-k];
        return r;
    endfunction

    task automatic expect_lane(input string name, input int idx,
                               input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s[%0d] exp %h got %h at addr %h", name, idx, exp, got, addr_m);
        end
    endtask

    task automatic check_outputs();
        int          vl;            // victim lane or -1 for none
        logic        known_word;
        logic [15:0] exp_w;
        logic [7:0]  aggr;
        logic [7:0]  vict;
        vl = -1;
        if (vic_on && int'(byte_m) < `CPLX_DBYTES) vl = int'(byte_m) * 8 + int'(vsel_m);
        chk_cnt++;
        if (rd_addr_i !== addr_m) begin
            err_cnt++;
            $display("ERR rd_addr_o exp %h got %h", addr_m, rd_addr_i);
        end
        known_word = 1'b0;
        exp_w      = '0;
        for (int r = 0; r < N_REF; r++) begin
            if (addr_m == REF_ADDR[r]) begin
                known_word  = 1'b1;
                exp_w       = REF_WORD[r];
                ref_seen[r] = 1'b1;
            end
        end
        if (!ISI_EN && addr_m >= `CPLX_ISI_BASE) known_word = 1'b1;   // masked region reads zero
        if (known_word) begin
            aggr = exp_w[15:8];
            vict = exp_w[7:0];
        end else begin
            // unlisted entry so lanes must agree with each other
            aggr = reverse_bits(cplx_data_i[((vl == 0) ? 8 : 0) +: 8]);
            vict = (vl >= 0) ? reverse_bits(cplx_data_i[vl*8 +: 8]) : aggr;
            if (vl < 0 && vic_on) vict = reverse_bits(cplx_byte_i[int'(vsel_m)*8 +: 8]);
            if ({aggr, vict} == 16'h0000) begin
                err_cnt++;
                $display("all lanes zero at address %0d, below the isi region", addr_m);
            end
        end
        for (int n = 0; n < `CPLX_DQ_WIDTH; n++) begin
            expect_lane("cplx_data_o", n, cplx_data_i[n*8 +: 8],
                        reverse_bits((n == vl) ? vict : aggr));
        end
        for (int i = 0; i < 8; i++) begin
            expect_lane("cplx_byte_o", i, cplx_byte_i[i*8 +: 8],
                        reverse_bits((vic_on && i == int'(vsel_m)) ? vict : aggr));
        end
        if (vl >= 0 && cplx_byte_i !== cplx_data_i[int'(byte_m)*64 +: 64]) begin
            err_cnt++;
            $display("ERR cplx_byte_o exp %h got %h", cplx_data_i[int'(byte_m)*64 +: 64],
                     cplx_byte_i);
        end
    endtask

    // outputs settled mid cycle and inputs here are sampled on the next edge
    always @(negedge clk_i) begin
        if (addr_known) begin
            check_outputs();
        end
        addr_known = cnt_known;     // output stage trails the counter by one edge
        addr_m     = cnt_m;
        if (rst_i) begin
            cnt_m     = '0;
            cnt_known = 1'b1;
            vic_on    = 1'b0;
        end else begin
            if (restart_i) begin
                cnt_m = '0;         // restart wins
            end else if (inc_i) begin
                cnt_m = (cnt_m == 8'hFF) ? 8'h00 : cnt_m + 8'h01;
            end
            vic_on = 1'b1;
            vsel_m = victim_sel_i;
            byte_m = byte_cnt_i;
        end
    end

endmodule

/* hdl/cplx_pattern_gen.sv */
//**********************************************************
// complex data pattern generator top
// pattern rom and victim decode feeding the lane mapper
//**********************************************************
`include "cplx_defines.svh"

module cplx_pattern_gen #(
    parameter bit VCCO_PAT_EN   = 1'b1,
    parameter bit VCCAUX_PAT_EN = 1'b1,
    parameter bit ISI_PAT_EN    = 1'b1
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                restart_i,
    input  logic                                inc_i,
    input  logic [2:0]                          victim_sel_i,
    input  logic [`CPLX_BYTE_CNT_W-1:0]         byte_cnt_i,
    output logic [`CPLX_DQ_WIDTH*`CPLX_BL-1:0]  cplx_data_o,
    output logic [8*`CPLX_BL-1:0]               cplx_byte_o,
    output logic [`CPLX_ADDR_W-1:0]             rd_addr_o
);

    cplx_pkg::pattern_word_t word;   // masked entry at rd_addr_o
    cplx_pkg::victim_sel_t   vsel;

    pattern_rom #(
        .VCCO_PAT_EN   (VCCO_PAT_EN),
        .VCCAUX_PAT_EN (VCCAUX_PAT_EN),
        .ISI_PAT_EN    (ISI_PAT_EN)
    ) pattern_rom_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .restart_i (restart_i),
        .inc_i     (inc_i),
        .rd_addr_o (rd_addr_o),
        .word_o    (word)
    );

    victim_decode victim_decode_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .victim_sel_i (victim_sel_i),
        .byte_cnt_i   (byte_cnt_i),
        .vsel_o       (vsel)
    );

    lane_mapper lane_mapper_inst (
        .word_i      (word),
        .vsel_i      (vsel),
        .cplx_data_o (cplx_data_o),
        .cplx_byte_o (cplx_byte_o)
    );

endmodule

/* hdl/lane_mapper.sv */
//**********************************************************
// lane mapper
// spreads the pattern word over all dq lanes as bl8
// and builds the single byte view
//**********************************************************
`include "cplx_defines.svh"

module lane_mapper (
    input  cplx_pkg::pattern_word_t               word_i,
    input  cplx_pkg::victim_sel_t                 vsel_i,
    output logic [`CPLX_DQ_WIDTH*`CPLX_BL-1:0]    cplx_data_o,   // bl8 per lane
    output logic [8*`CPLX_BL-1:0]                 cplx_byte_o    // one byte, 8 lanes
);

    //**********************************************************
    // one lane worth of burst data
    //**********************************************************
    // burst beat k carries pattern bit 7-k, msb goes out first
    function automatic logic [`CPLX_BL-1:0] lane_bits(
        input cplx_pkg::pattern_word_t w,
        input logic                    is_victim
    );
        logic [7:0]          src;
        logic [`CPLX_BL-1:0] bl;
        src = is_victim ? w.victim : w.aggr;
        for (int k = 0; k < `CPLX_BL; k++) begin
            bl[k] = src[7-k];
        end
        return bl;
    endfunction

    // full bus, lane n at n*8
    always_comb begin
        for (int n = 0; n < `CPLX_DQ_WIDTH; n++) begin
            cplx_data_o[n*`CPLX_BL +: `CPLX_BL] = lane_bits(word_i, vsel_i.lane_sel[n]);
        end
    end

    // byte view, victim picked by bit_sel only
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            cplx_byte_o[i*`CPLX_BL +: `CPLX_BL] = lane_bits(word_i, vsel_i.bit_sel[i]);
        end
    end

endmodule

/* hdl/victim_decode.sv */
//**********************************************************
// victim decode
// one-hot victim lane and victim bit, registered
//**********************************************************
`include "cplx_defines.svh"

module victim_decode (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [2:0]                  victim_sel_i,   // bit within the byte
    input  logic [`CPLX_BYTE_CNT_W-1:0] byte_cnt_i,     // byte under test
    output cplx_pkg::victim_sel_t       vsel_o
);

    localparam int IDX_W = `CPLX_BYTE_CNT_W + 3;

    logic [IDX_W-1:0]      lane_idx;
    cplx_pkg::victim_sel_t vsel_d;
    cplx_pkg::victim_sel_t vsel_q;

    assign lane_idx = {byte_cnt_i, victim_sel_i};   // byte_cnt * 8 + victim_sel

    // byte selects past the last byte leave every lane aggressor
    always_comb begin
        vsel_d = '0;
        for (int n = 0; n < `CPLX_DQ_WIDTH; n++) begin
            vsel_d.lane_sel[n] = (lane_idx == IDX_W'(n));
        end
        for (int b = 0; b < 8; b++) begin
            vsel_d.bit_sel[b] = (victim_sel_i == 3'(b));
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vsel_q <= '0;          // no victim after reset
        end else begin
            vsel_q <= vsel_d;
        end
    end

    assign vsel_o = vsel_q;

endmodule

/* hdl/pattern_rom.sv */
//**********************************************************
// complex pattern rom
// read address counter, 256 entry pattern table and
// per region enable masking of the registered word
//**********************************************************
`include "cplx_defines.svh"

module pattern_rom #(
    parameter bit VCCO_PAT_EN   = 1'b1,
    parameter bit VCCAUX_PAT_EN = 1'b1,
    parameter bit ISI_PAT_EN    = 1'b1    // also covers spare region
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      restart_i,   // back to address 0
    input  logic                      inc_i,       // step one entry
    output logic [`CPLX_ADDR_W-1:0]   rd_addr_o,
    output cplx_pkg::pattern_word_t   word_o
);

    localparam logic [`CPLX_ADDR_W-1:0] ADDR_MAX = `CPLX_ADDR_W'(`CPLX_ROM_DEPTH - 1);

    logic [`CPLX_ADDR_W-1:0] cnt_q, cnt_d;   // rom read address
    logic [`CPLX_ADDR_W-1:0] rd_addr_q;      // address of word_q
    logic [4:0]              vcco_idx;       // offset within a vcco region
    logic [7:0]              vcco_aggr;
    cplx_pkg::region_e       region;
    logic                    region_en;
    cplx_pkg::pattern_word_t ext_word;       // entries from vccaux upward
    cplx_pkg::pattern_word_t rom_word;
    cplx_pkg::pattern_word_t word_q;

    //**********************************************************
    // address counter
    //**********************************************************
    always_comb begin
        cnt_d = cnt_q;
        if (restart_i) begin
            cnt_d = '0;                          // restart beats increment
        end else if (inc_i) begin
            cnt_d = (cnt_q == ADDR_MAX) ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // region of the current counter address
    always_comb begin
        if (cnt_q < `CPLX_VCCO_INV_BASE)    region = cplx_pkg::REGION_VCCO_MATCH;
        else if (cnt_q < `CPLX_VCCAUX_BASE) region = cplx_pkg::REGION_VCCO_INV;
        else if (cnt_q < `CPLX_ISI_BASE)    region = cplx_pkg::REGION_VCCAUX;
        else if (cnt_q < `CPLX_SPARE_BASE)  region = cplx_pkg::REGION_ISI;
        else                                region = cplx_pkg::REGION_SPARE;
    end

    // each region follows only its own enable
    always_comb begin
        case (region)
            cplx_pkg::REGION_VCCO_MATCH,
            cplx_pkg::REGION_VCCO_INV:   region_en = VCCO_PAT_EN;
            cplx_pkg::REGION_VCCAUX:     region_en = VCCAUX_PAT_EN;
            cplx_pkg::REGION_ISI,
            cplx_pkg::REGION_SPARE:      region_en = ISI_PAT_EN;
            default:                     region_en = 1'b0;
        endcase
    end

    //**********************************************************
    // vcco aggressor table, shared by both vcco regions
    //**********************************************************
    assign vcco_idx = (cnt_q < `CPLX_VCCO_INV_BASE) ? cnt_q[4:0]
                                                    : 5'(cnt_q - `CPLX_VCCO_INV_BASE);

    always_comb begin
        case (vcco_idx)
            5'd0    : vcco_aggr = 8'hAA;   // 1 read
            5'd1    : vcco_aggr = 8'hCC;   // 2 reads
            5'd2    : vcco_aggr = 8'hCC;
            5'd3    : vcco_aggr = 8'hE3;   // 3 reads
            5'd4    : vcco_aggr = 8'h8E;
            5'd5    : vcco_aggr = 8'h38;
            5'd6    : vcco_aggr = 8'hF0;   // 4 reads
            5'd7    : vcco_aggr = 8'hF0;
            5'd8    : vcco_aggr = 8'hF0;
            5'd9    : vcco_aggr = 8'hF0;
            5'd10   : vcco_aggr = 8'hF8;   // 5 reads
            5'd11   : vcco_aggr = 8'h3E;
            5'd12   : vcco_aggr = 8'h0F;
            5'd13   : vcco_aggr = 8'h83;
            5'd14   : vcco_aggr = 8'hE0;
            5'd15   : vcco_aggr = 8'hFC;   // 6 reads
            5'd16   : vcco_aggr = 8'h0F;
            5'd17   : vcco_aggr = 8'hC0;
            5'd18   : vcco_aggr = 8'hFC;
            5'd19   : vcco_aggr = 8'h0F;
            5'd20   : vcco_aggr = 8'hC0;
            default : vcco_aggr = 8'h00;   // outside both vcco regions
        endcase
    end

    //**********************************************************
    // vccaux, isi and spare entries as {aggr, victim}
    //**********************************************************
    always_comb begin
        case (cnt_q)
            8'd42   : ext_word = 16'hB457;   // vccaux 3 reads
            8'd43   : ext_word = 16'hB46F;
            8'd44   : ext_word = 16'hB4C0;
            8'd45   : ext_word = 16'hA284;   // 4 reads
            8'd46   : ext_word = 16'h8A31;
            8'd47   : ext_word = 16'h2847;
            8'd48   : ext_word = 16'hA225;
            8'd49   : ext_word = 16'hAF9A;   // 5 reads
            8'd50   : ext_word = 16'h507A;
            8'd51   : ext_word = 16'hAF95;
            8'd52   : ext_word = 16'h50DB;
            8'd53   : ext_word = 16'hAFF0;
            8'd54   : ext_word = 16'hA821;   // 7 reads
            8'd55   : ext_word = 16'h2A8A;
            8'd56   : ext_word = 16'h0A25;
            8'd57   : ext_word = 16'h829A;
            8'd58   : ext_word = 16'hA07A;
            8'd59   : ext_word = 16'hA8BF;
            8'd60   : ext_word = 16'h2A57;
            8'd61   : ext_word = 16'hAB6F;   // 8 reads
            8'd62   : ext_word = 16'hF5C0;
            8'd63   : ext_word = 16'h4084;
            8'd64   : ext_word = 16'hAB31;
            8'd65   : ext_word = 16'hF547;
            8'd66   : ext_word = 16'h4025;
            8'd67   : ext_word = 16'hAB9A;
            8'd68   : ext_word = 16'hF57A;
            8'd69   : ext_word = 16'hAA95;   // 9 reads
            8'd70   : ext_word = 16'h02DB;
            8'd71   : ext_word = 16'hA8F0;
            8'd72   : ext_word = 16'h0A21;
            8'd73   : ext_word = 16'hA08A;
            8'd74   : ext_word = 16'h2A25;
            8'd75   : ext_word = 16'h809A;
            8'd76   : ext_word = 16'hAA7A;
            8'd77   : ext_word = 16'h02BF;
            8'd78   : ext_word = 16'hAA57;   // 10 reads
            8'd79   : ext_word = 16'hFF6F;
            8'd80   : ext_word = 16'h55C0;
            8'd81   : ext_word = 16'h0084;
            8'd82   : ext_word = 16'hAA31;
            8'd83   : ext_word = 16'hFF47;
            8'd84   : ext_word = 16'h5525;
            8'd85   : ext_word = 16'h009A;
            8'd86   : ext_word = 16'hAA7A;
            8'd87   : ext_word = 16'hFF95;
            8'd88   : ext_word = 16'hAADB;   // 12 reads
            8'd89   : ext_word = 16'h80F0;
            8'd90   : ext_word = 16'h2A21;
            8'd91   : ext_word = 16'hA08A;
            8'd92   : ext_word = 16'h0A25;
            8'd93   : ext_word = 16'hA89A;
            8'd94   : ext_word = 16'h027A;
            8'd95   : ext_word = 16'hAABF;
            8'd96   : ext_word = 16'h0057;
            8'd97   : ext_word = 16'hAA6F;
            8'd98   : ext_word = 16'h80C0;
            8'd99   : ext_word = 16'h2A84;
            8'd100  : ext_word = 16'hAA31;   // 13 reads
            8'd101  : ext_word = 16'hBF47;
            8'd102  : ext_word = 16'hF525;
            8'd103  : ext_word = 16'h549A;
            8'd104  : ext_word = 16'h007A;
            8'd105  : ext_word = 16'hAA95;
            8'd106  : ext_word = 16'hBFDB;
            8'd107  : ext_word = 16'hF5F0;
            8'd108  : ext_word = 16'h5421;
            8'd109  : ext_word = 16'h008A;
            8'd110  : ext_word = 16'hAA25;
            8'd111  : ext_word = 16'hBF9A;
            8'd112  : ext_word = 16'hF57A;
            8'd113  : ext_word = 16'hAABF;   // 14 reads
            8'd114  : ext_word = 16'hA057;
            8'd115  : ext_word = 16'h026F;
            8'd116  : ext_word = 16'hAAC0;
            8'd117  : ext_word = 16'h8084;
            8'd118  : ext_word = 16'h0A31;
            8'd119  : ext_word = 16'hAA47;
            8'd120  : ext_word = 16'h0025;
            8'd121  : ext_word = 16'h2A9A;
            8'd122  : ext_word = 16'hA87A;
            8'd123  : ext_word = 16'h0095;
            8'd124  : ext_word = 16'hAADB;
            8'd125  : ext_word = 16'hA0F0;
            8'd126  : ext_word = 16'h0221;
            8'd127  : ext_word = 16'h5757;   // isi, back-to-back reads
            8'd128  : ext_word = 16'h6F6F;
            8'd129  : ext_word = 16'hC0C0;
            8'd130  : ext_word = 16'h8684;
            8'd131  : ext_word = 16'h2831;
            8'd132  : ext_word = 16'hE447;
            8'd133  : ext_word = 16'hB325;
            8'd134  : ext_word = 16'h4F9B;
            8'd135  : ext_word = 16'hB555;
            8'd136  : ext_word = 16'hB555;
            8'd137  : ext_word = 16'h8798;
            8'd138  : ext_word = 16'hE31C;
            8'd139  : ext_word = 16'h0AF5;
            8'd140  : ext_word = 16'hD42B;
            8'd141  : ext_word = 16'h48B7;
            8'd142  : ext_word = 16'h1FE0;
            8'd143  : ext_word = 16'hBC43;
            8'd144  : ext_word = 16'h8F14;
            8'd145  : ext_word = 16'hB44B;
            8'd146  : ext_word = 16'hCB34;
            8'd147  : ext_word = 16'h0AF5;
            8'd148  : ext_word = 16'h8000;
            8'd149  : ext_word = 16'h0000;   // extra isi entries
            8'd150  : ext_word = 16'h5555;
            8'd151  : ext_word = 16'h5555;
            8'd152  : ext_word = 16'h0000;
            8'd153  : ext_word = 16'h0000;
            8'd154  : ext_word = 16'h552A;
            8'd155  : ext_word = 16'h55AA;
            8'd156  : ext_word = 16'h0080;
            default : ext_word = `CPLX_SPARE_WORD;   // spare 157..255
        endcase
    end

    // vcco victim is the aggressor itself or its inverse
    always_comb begin
        case (region)
            cplx_pkg::REGION_VCCO_MATCH: rom_word = {vcco_aggr, vcco_aggr};
            cplx_pkg::REGION_VCCO_INV:   rom_word = {vcco_aggr, ~vcco_aggr};
            default:                     rom_word = ext_word;
        endcase
    end

    //**********************************************************
    // output stage, word and address move together
    //**********************************************************
    always_ff @(posedge clk_i) begin
        rd_addr_q <= cnt_q;
        word_q    <= region_en ? rom_word : '0;   // masked region reads zero
    end

    assign rd_addr_o = rd_addr_q;
    assign word_o    = word_q;

endmodule

/* hdl/cplx_pkg.sv */
//**********************************************************
// complex pattern generator types
// rom word, victim select and rom region
//**********************************************************
`include "cplx_defines.svh"

package cplx_pkg;

    // one rom entry, aggressor in the upper byte
    typedef struct packed {
        logic [7:0] aggr;      // pattern on every other lane
        logic [7:0] victim;    // pattern on the victim lane
    } pattern_word_t;

    // registered victim position
    typedef struct packed {
        logic [`CPLX_DQ_WIDTH-1:0] lane_sel;  // one-hot over all dq lanes
        logic [7:0]                bit_sel;   // one-hot within a byte
    } victim_sel_t;

    //**********************************************************
    // rom regions, in address order
    //**********************************************************
    typedef enum logic [2:0] {
        REGION_VCCO_MATCH = 3'd0,   // vcco noise, victim = aggressor
        REGION_VCCO_INV   = 3'd1,   // vcco noise, victim inverted
        REGION_VCCAUX     = 3'd2,   // vccaux noise, isi victim
        REGION_ISI        = 3'd3,   // back-to-back isi
        REGION_SPARE      = 3'd4    // unused entries
    } region_e;

endpackage

/* hdl/cplx_defines.svh */
//**********************************************************
// complex pattern generator constants
// bus widths, pattern rom geometry and region bounds
//**********************************************************
`ifndef CPLX_DEFINES_SVH
`define CPLX_DEFINES_SVH

// data bus geometry
`define CPLX_DBYTES          4                    // data bytes
`define CPLX_DQ_WIDTH        (`CPLX_DBYTES * 8)   // dq lanes
`define CPLX_BL              8                    // burst of 8

// pattern rom
`define CPLX_ADDR_W          8
`define CPLX_ROM_DEPTH       256
`define CPLX_BYTE_CNT_W      5                    // byte select width

// region start addresses, vcco match region starts at 0
`define CPLX_VCCO_INV_BASE   8'd21
`define CPLX_VCCAUX_BASE     8'd42
`define CPLX_ISI_BASE        8'd127
`define CPLX_SPARE_BASE      8'd157

`define CPLX_SPARE_WORD      16'h0101             // aggr 01, victim 01

`endif
